/* cache_be.f */
design/cache_be_pkg.sv
design/cache_be_wtb_ram.sv
design/cache_be_wtb_fifo.sv
design/cache_be_refill.sv
design/cache_be_ctrl.sv
design/cache_be_top.sv
verif/cache_be_mem_model.sv
verif/cache_be_tb.sv

/* design/cache_be_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_be_ctrl (
   input  logic                               clk_i,
   input  logic                               rst_i,
   // front end
   input  logic                               fe_avalid_i,
   input  logic [cache_be_pkg::ADDR_W-1:0]    fe_addr_i,
   input  logic [cache_be_pkg::NBYTES-1:0]    fe_wstrb_i,
   output logic                               fe_ready_o,
   // write-through buffer
   input  logic                               wtb_full_i,
   input  logic                               wtb_empty_i,
   output logic                               wtb_push_o,
   output logic                               wtb_pop_o,
   input  logic [cache_be_pkg::WTB_DATA_W-1:0] wtb_rdata_i,
   // refill datapath
   output logic                               refill_start_o,
   output logic [cache_be_pkg::ADDR_W-1:0]    refill_base_o,
   output logic                               refill_issue_o,
   input  logic [cache_be_pkg::ADDR_W-1:0]    refill_addr_i,
   input  logic                               refill_done_i,
   // back end
   output logic                               be_avalid_o,
   output logic [cache_be_pkg::ADDR_W-1:0]    be_addr_o,
   output logic [cache_be_pkg::DATA_W-1:0]    be_wdata_o,
   output logic [cache_be_pkg::NBYTES-1:0]    be_wstrb_o,
   input  logic                               be_ready_i
);

   logic [cache_be_pkg::ST_W-1:0] state_q;
   logic [cache_be_pkg::ST_W-1:0] state_d;
   logic                          fe_wr;
   logic                          fe_accept;
   logic                          refill_busy;
   logic                          draining;
   logic                          last_issue;

   assign fe_wr       = |fe_wstrb_i;
   assign refill_busy = (state_q == cache_be_pkg::ST_REFILL_ISSUE) ||
                        (state_q == cache_be_pkg::ST_REFILL_WAIT);
   assign draining    = (state_q == cache_be_pkg::ST_DRAIN_REQ) ||
                        (state_q == cache_be_pkg::ST_DRAIN_WAIT);

   // reads wait for an empty buffer so they see every earlier write
   assign fe_ready_o = !refill_busy &&
      (fe_wr ? !wtb_full_i : ((state_q == cache_be_pkg::ST_IDLE) && wtb_empty_i));
   assign fe_accept  = fe_avalid_i && fe_ready_o;

   assign wtb_push_o     = fe_accept && fe_wr;
   assign wtb_pop_o      = (state_q == cache_be_pkg::ST_IDLE) && !wtb_empty_i;
   assign refill_start_o = fe_accept && !fe_wr;
   // clear word and byte offset to get the line base
   assign refill_base_o  = {fe_addr_i[cache_be_pkg::ADDR_W-1:
                                      cache_be_pkg::LINE_OFF_W+cache_be_pkg::BYTE_OFF_W],
                            {(cache_be_pkg::LINE_OFF_W+cache_be_pkg::BYTE_OFF_W){1'b0}}};
   assign refill_issue_o = (state_q == cache_be_pkg::ST_REFILL_ISSUE) && be_ready_i;
   assign last_issue     = refill_issue_o &&
      (refill_addr_i[cache_be_pkg::BYTE_OFF_W +: cache_be_pkg::LINE_OFF_W] ==
       (cache_be_pkg::LINE_OFF_W)'(cache_be_pkg::LINE_WORDS - 1));

   // drain payload comes from the RAM read register, which holds between pops
   assign be_avalid_o = draining || (state_q == cache_be_pkg::ST_REFILL_ISSUE);
   assign be_addr_o   = draining ?
      wtb_rdata_i[cache_be_pkg::WTB_DATA_W-1 -: cache_be_pkg::ADDR_W] : refill_addr_i;
   assign be_wdata_o  = wtb_rdata_i[cache_be_pkg::NBYTES +: cache_be_pkg::DATA_W];
   assign be_wstrb_o  = draining ? wtb_rdata_i[0 +: cache_be_pkg::NBYTES] : '0;

   always_comb begin
      state_d = state_q;
      case (state_q)
         cache_be_pkg::ST_IDLE: begin
            if (wtb_pop_o) begin
               state_d = cache_be_pkg::ST_DRAIN_REQ;
            end else if (refill_start_o) begin
               state_d = cache_be_pkg::ST_REFILL_ISSUE;
            end
         end
         // first cycle of a drain write
         cache_be_pkg::ST_DRAIN_REQ: begin
            state_d = be_ready_i ? cache_be_pkg::ST_IDLE : cache_be_pkg::ST_DRAIN_WAIT;
         end
         // memory stalled, keep the write up
         cache_be_pkg::ST_DRAIN_WAIT: begin
            if (be_ready_i) begin
               state_d = cache_be_pkg::ST_IDLE;
            end
         end
         cache_be_pkg::ST_REFILL_ISSUE: begin
            if (last_issue) begin
               state_d = cache_be_pkg::ST_REFILL_WAIT;
            end
         end
         cache_be_pkg::ST_REFILL_WAIT: begin
            if (refill_done_i) begin
               state_d = cache_be_pkg::ST_IDLE;
            end
         end
         default: state_d = cache_be_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= cache_be_pkg::ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // a stalled back-end request keeps its payload
   a_be_req_stable: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (be_avalid_o && !be_ready_i) |=>
         (be_avalid_o && $stable(be_addr_o) && $stable(be_wdata_o) && $stable(be_wstrb_o))
   ) else $error("back-end request changed before ready");

endmodule

`default_nettype wire

/* design/cache_be_pkg.sv */
`default_nettype none

package cache_be_pkg;

   // word geometry, shared by front end and back end
   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int NBYTES     = DATA_W / 8;
   localparam int BYTE_OFF_W = 2;

   // write-through buffer, 8 entries
   localparam int WTB_DEPTH_W = 3;
   localparam int WTB_DEPTH   = 1 << WTB_DEPTH_W;
   // entry is {addr, data, strobes}, strobes in the low bits
   localparam int WTB_DATA_W  = ADDR_W + DATA_W + NBYTES;

   // refill line geometry
   localparam int LINE_WORDS = 4;
   localparam int LINE_OFF_W = 2;
   localparam int LINE_W     = LINE_WORDS * DATA_W;

   // control FSM state codes
   localparam int ST_W = 3;
   localparam logic [ST_W-1:0] ST_IDLE         = 3'd0;
   localparam logic [ST_W-1:0] ST_DRAIN_WAIT   = 3'd1;
   localparam logic [ST_W-1:0] ST_DRAIN_REQ    = 3'd2;
   localparam logic [ST_W-1:0] ST_REFILL_ISSUE = 3'd3;
   localparam logic [ST_W-1:0] ST_REFILL_WAIT  = 3'd4;

endpackage

`default_nettype wire

/* design/cache_be_refill.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_be_refill (
   input  logic                              clk_i,
   input  logic                              rst_i,
   // from the controller
   input  logic                              start_i,
   input  logic [cache_be_pkg::ADDR_W-1:0]   base_addr_i,
   input  logic                              issue_i,
   output logic [cache_be_pkg::ADDR_W-1:0]   word_addr_o,
   // back-end read responses
   input  logic                              rvalid_i,
   input  logic [cache_be_pkg::DATA_W-1:0]   rdata_i,
   // assembled line
   output logic [cache_be_pkg::LINE_W-1:0]   line_o,
   output logic                              done_o
);

   logic [cache_be_pkg::ADDR_W-1:cache_be_pkg::LINE_OFF_W+cache_be_pkg::BYTE_OFF_W] base_q;
   logic [cache_be_pkg::LINE_OFF_W:0] issue_cnt_q;
   logic [cache_be_pkg::LINE_OFF_W:0] resp_cnt_q;
   logic [cache_be_pkg::LINE_W-1:0]   line_q;
   logic                              done_q;
   logic                              last_resp;

   assign last_resp = rvalid_i &&
      (resp_cnt_q == (cache_be_pkg::LINE_OFF_W + 1)'(cache_be_pkg::LINE_WORDS - 1));

   // next word to request: line base plus issued count
   assign word_addr_o = {base_q,
                         issue_cnt_q[cache_be_pkg::LINE_OFF_W-1:0],
                         {cache_be_pkg::BYTE_OFF_W{1'b0}}};

   assign line_o = line_q;
   assign done_o = done_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         issue_cnt_q <= '0;
         resp_cnt_q  <= '0;
         done_q      <= 1'b0;
      end else begin
         // done lines up with the last word landing in line_q
         done_q <= last_resp;
         if (start_i) begin
            issue_cnt_q <= '0;
            resp_cnt_q  <= '0;
         end else begin
            if (issue_i) begin
               issue_cnt_q <= issue_cnt_q + 1'b1;
            end
            if (rvalid_i) begin
               resp_cnt_q <= resp_cnt_q + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i) begin
         base_q <= base_addr_i[cache_be_pkg::ADDR_W-1:
                               cache_be_pkg::LINE_OFF_W+cache_be_pkg::BYTE_OFF_W];
      end
   end

   // responses come back in order, word 0 ends up in the low bits
   always_ff @(posedge clk_i) begin
      if (rvalid_i) begin
         line_q <= {rdata_i, line_q[cache_be_pkg::LINE_W-1:cache_be_pkg::DATA_W]};
      end
   end

   // memory only answers reads that were issued
   a_resp_le_issue: assert property (
      @(posedge clk_i) disable iff (rst_i)
      rvalid_i |-> (resp_cnt_q < issue_cnt_q)
   ) else $error("refill response without an outstanding read");

endmodule

`default_nettype wire

/* design/cache_be_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_be_top (
   input  logic                              clk_i,
   input  logic                              rst_i,
   // front end
   input  logic                              fe_avalid_i,
   input  logic [cache_be_pkg::ADDR_W-1:0]   fe_addr_i,
   input  logic [cache_be_pkg::DATA_W-1:0]   fe_wdata_i,
   input  logic [cache_be_pkg::NBYTES-1:0]   fe_wstrb_i,
   output logic                              fe_ready_o,
   output logic [cache_be_pkg::LINE_W-1:0]   fe_line_o,
   output logic                              fe_line_valid_o,
   // back end
   output logic                              be_avalid_o,
   output logic [cache_be_pkg::ADDR_W-1:0]   be_addr_o,
   output logic [cache_be_pkg::DATA_W-1:0]   be_wdata_o,
   output logic [cache_be_pkg::NBYTES-1:0]   be_wstrb_o,
   input  logic                              be_ready_i,
   input  logic                              be_rvalid_i,
   input  logic [cache_be_pkg::DATA_W-1:0]   be_rdata_i,
   // buffer status
   output logic                              wtb_empty_o,
   output logic                              wtb_full_o,
   output logic [cache_be_pkg::WTB_DEPTH_W:0] wtb_level_o
);

   logic                                 wtb_push;
   logic                                 wtb_pop;
   logic [cache_be_pkg::WTB_DATA_W-1:0]  wtb_rdata;

   logic                                 ram_w_en;
   logic [cache_be_pkg::WTB_DEPTH_W-1:0] ram_w_addr;
   logic [cache_be_pkg::WTB_DATA_W-1:0]  ram_w_data;
   logic                                 ram_r_en;
   logic [cache_be_pkg::WTB_DEPTH_W-1:0] ram_r_addr;
   logic [cache_be_pkg::WTB_DATA_W-1:0]  ram_r_data;

   logic                                 refill_start;
   logic [cache_be_pkg::ADDR_W-1:0]      refill_base;
   logic                                 refill_issue;
   logic [cache_be_pkg::ADDR_W-1:0]      refill_addr;

   cache_be_ctrl ctrl_i (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .fe_avalid_i    (fe_avalid_i),
      .fe_addr_i      (fe_addr_i),
      .fe_wstrb_i     (fe_wstrb_i),
      .fe_ready_o     (fe_ready_o),
      .wtb_full_i     (wtb_full_o),
      .wtb_empty_i    (wtb_empty_o),
      .wtb_push_o     (wtb_push),
      .wtb_pop_o      (wtb_pop),
      .wtb_rdata_i    (wtb_rdata),
      .refill_start_o (refill_start),
      .refill_base_o  (refill_base),
      .refill_issue_o (refill_issue),
      .refill_addr_i  (refill_addr),
      .refill_done_i  (fe_line_valid_o),
      .be_avalid_o    (be_avalid_o),
      .be_addr_o      (be_addr_o),
      .be_wdata_o     (be_wdata_o),
      .be_wstrb_o     (be_wstrb_o),
      .be_ready_i     (be_ready_i)
   );

   // buffer entry layout {addr, data, strobes}
   cache_be_wtb_fifo wtb_fifo_i (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .w_en_i           (wtb_push),
      .w_data_i         ({fe_addr_i, fe_wdata_i, fe_wstrb_i}),
      .w_full_o         (wtb_full_o),
      .r_en_i           (wtb_pop),
      .r_data_o         (wtb_rdata),
      .r_empty_o        (wtb_empty_o),
      .level_o          (wtb_level_o),
      .ext_mem_w_en_o   (ram_w_en),
      .ext_mem_w_addr_o (ram_w_addr),
      .ext_mem_w_data_o (ram_w_data),
      .ext_mem_r_en_o   (ram_r_en),
      .ext_mem_r_addr_o (ram_r_addr),
      .ext_mem_r_data_i (ram_r_data)
   );

   cache_be_wtb_ram wtb_ram_i (
      .clk_i    (clk_i),
      .w_en_i   (ram_w_en),
      .w_addr_i (ram_w_addr),
      .w_data_i (ram_w_data),
      .r_en_i   (ram_r_en),
      .r_addr_i (ram_r_addr),
      .r_data_o (ram_r_data)
   );

   cache_be_refill refill_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .start_i     (refill_start),
      .base_addr_i (refill_base),
      .issue_i     (refill_issue),
      .word_addr_o (refill_addr),
      .rvalid_i    (be_rvalid_i),
      .rdata_i     (be_rdata_i),
      .line_o      (fe_line_o),
      .done_o      (fe_line_valid_o)
   );

endmodule

`default_nettype wire

/* design/cache_be_wtb_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_be_wtb_fifo (
   input  logic                                 clk_i,
   input  logic                                 rst_i,
   // write side
   input  logic                                 w_en_i,
   input  logic [cache_be_pkg::WTB_DATA_W-1:0]  w_data_i,
   output logic                                 w_full_o,
   // read side
   input  logic                                 r_en_i,
   output logic [cache_be_pkg::WTB_DATA_W-1:0]  r_data_o,
   output logic                                 r_empty_o,
   // status
   output logic [cache_be_pkg::WTB_DEPTH_W:0]   level_o,
   // buffer RAM
   output logic                                 ext_mem_w_en_o,
   output logic [cache_be_pkg::WTB_DEPTH_W-1:0] ext_mem_w_addr_o,
   output logic [cache_be_pkg::WTB_DATA_W-1:0]  ext_mem_w_data_o,
   output logic                                 ext_mem_r_en_o,
   output logic [cache_be_pkg::WTB_DEPTH_W-1:0] ext_mem_r_addr_o,
   input  logic [cache_be_pkg::WTB_DATA_W-1:0]  ext_mem_r_data_i
);

   logic [cache_be_pkg::WTB_DEPTH_W-1:0] w_ptr_q;
   logic [cache_be_pkg::WTB_DEPTH_W-1:0] r_ptr_q;
   logic [cache_be_pkg::WTB_DEPTH_W:0]   level_q;
   logic                                 push;
   logic                                 pop;

   // depth is a power of two, so the level MSB alone means full
   assign w_full_o  = level_q[cache_be_pkg::WTB_DEPTH_W];
   assign r_empty_o = (level_q == '0);
   assign level_o   = level_q;

   // requests past the limits are dropped
   assign push = w_en_i & ~w_full_o;
   assign pop  = r_en_i & ~r_empty_o;

   assign ext_mem_w_en_o   = push;
   assign ext_mem_w_addr_o = w_ptr_q;
   assign ext_mem_w_data_o = w_data_i;
   assign ext_mem_r_en_o   = pop;
   assign ext_mem_r_addr_o = r_ptr_q;

   // read data comes straight from the RAM, one cycle after the pop
   assign r_data_o = ext_mem_r_data_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
         level_q <= '0;
      end else begin
         if (push) begin
            w_ptr_q <= w_ptr_q + 1'b1;
         end
         if (pop) begin
            r_ptr_q <= r_ptr_q + 1'b1;
         end
         // simultaneous push and pop leave the level alone
         case ({push, pop})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   // the controller never pushes into a full buffer or pops an empty one
   a_wtb_no_overrun: assert property (
      @(posedge clk_i) disable iff (rst_i)
      !(w_en_i && w_full_o) && !(r_en_i && r_empty_o)
   ) else $error("wtb push when full or pop when empty");

endmodule

`default_nettype wire

/* design/cache_be_wtb_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_be_wtb_ram (
   input  logic                                clk_i,
   input  logic                                w_en_i,
   input  logic [cache_be_pkg::WTB_DEPTH_W-1:0] w_addr_i,
   input  logic [cache_be_pkg::WTB_DATA_W-1:0]  w_data_i,
   input  logic                                r_en_i,
   input  logic [cache_be_pkg::WTB_DEPTH_W-1:0] r_addr_i,
   output logic [cache_be_pkg::WTB_DATA_W-1:0]  r_data_o
);

   logic [cache_be_pkg::WTB_DATA_W-1:0] mem [cache_be_pkg::WTB_DEPTH];

   // write port
   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // registered read, the word stays on r_data_o until the next read
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the cache back-end testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cache_be_tb -f cache_be.f \
   && ./obj_dir/Vcache_be_tb | tee /dev/stderr | grep -q "Finished with no errors" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

/* verif/cache_be_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_be_mem_model (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        ready_en_i,
   input  logic        avalid_i,
   input  logic [31:0] addr_i,
   input  logic [31:0] wdata_i,
   input  logic [3:0]  wstrb_i,
   output logic        ready_o,
   output logic        rvalid_o,
   output logic [31:0] rdata_o
);

   logic [31:0] mem [logic [31:0]];
   logic [31:0] rd_data_q [$];
   longint      rd_due_q [$];

   // untouched words read back as their inverted address
   function automatic logic [31:0] load_word(input logic [31:0] a);
      return mem.exists(a) ? mem[a] : ~a;
   endfunction

   initial begin
      longint      cyc;
      longint      due;
      longint      lat;
      logic [31:0] wa;
      logic [31:0] word;
      cyc = 0;
      due = 0;
      ready_o = 1'b0;
      rvalid_o = 1'b0;
      rdata_o = '0;
      forever begin
         @(posedge clk_i);
         cyc++;
         wa = {addr_i[31:2], 2'b00};
         if (!rst_i && avalid_i && ready_o && wstrb_i != '0) begin
            word = load_word(wa);
            for (int b = 0; b < 4; b++) begin
               if (wstrb_i[b]) word[8*b +: 8] = wdata_i[8*b +: 8];
            end
            mem[wa] = word;
         end else if (!rst_i && avalid_i && ready_o) begin
            // 1 to 3 cycles, never ahead of an older read
            lat = cyc + 1 + longint'($urandom % 3);
            due = (lat > due) ? lat : due + 1;
            rd_data_q.push_back(load_word(wa));
            rd_due_q.push_back(due);
         end
         rvalid_o <= 1'b0;
         if (rd_due_q.size() != 0 && rd_due_q[0] <= cyc) begin
            rvalid_o <= 1'b1;
            rdata_o <= rd_data_q.pop_front();
            void'(rd_due_q.pop_front());
         end
         ready_o <= !rst_i && ready_en_i && ($urandom % 4 != 0);
      end
   end

endmodule

`default_nettype wire

/* verif/cache_be_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_be_tb;

   localparam int TIMEOUT = 500;

   logic clk_i, rst_i, fe_avalid_i, fe_ready_o, fe_line_valid_o, mem_ready_en;
   logic be_avalid_o, be_ready_i, be_rvalid_i, wtb_empty_o, wtb_full_o;
   logic [cache_be_pkg::ADDR_W-1:0]     fe_addr_i, be_addr_o, line_base;
   logic [cache_be_pkg::DATA_W-1:0]     fe_wdata_i, be_wdata_o, be_rdata_i;
   logic [cache_be_pkg::NBYTES-1:0]     fe_wstrb_i, be_wstrb_o;
   logic [cache_be_pkg::LINE_W-1:0]     fe_line_o, exp_line;
   logic [cache_be_pkg::WTB_DEPTH_W:0]  wtb_level_o;
   // expected back-end writes, in front-end order
   logic [cache_be_pkg::WTB_DATA_W-1:0] exp_wr_q [256];
   logic [cache_be_pkg::WTB_DATA_W-1:0] exp_head;
   bit   [7:0]                          exp_rd, exp_wr;
   logic [31:0]                         shadow [logic [31:0]];
   int                                  err_cnt, wr_cnt, drn_cnt, line_cnt, rd_idx;
   int                                  wtb_occ;
   bit                                  timed_out;

   assign exp_head = exp_wr_q[exp_rd];
   // entries still held by the buffer
   assign wtb_occ  = wr_cnt - drn_cnt - int'(be_avalid_o && be_wstrb_o != '0);

   cache_be_top dut_i (.*);

   cache_be_mem_model mem_model_i (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .ready_en_i (mem_ready_en),
      .avalid_i   (be_avalid_o),
      .addr_i     (be_addr_o),
      .wdata_i    (be_wdata_o),
      .wstrb_i    (be_wstrb_o),
      .ready_o    (be_ready_i),
      .rvalid_o   (be_rvalid_i),
      .rdata_o    (be_rdata_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   function automatic logic [31:0] shadow_word(input logic [31:0] a);
      return shadow.exists(a) ? shadow[a] : ~a;
   endfunction

   task automatic log_error(input string msg);
      err_cnt++;
      $display("ERR %0t: %s", $time, msg);
   endtask

   task automatic end_run();
      $display("writes %0d drained %0d lines %0d errors %0d", wr_cnt, drn_cnt, line_cnt,
               err_cnt);
      if (err_cnt == 0 && !timed_out) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   endtask

   // hold the request until it is taken, returns on the accepting edge
   task automatic send_req(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
      int n;
      if (!timed_out) begin
         @(posedge clk_i);
         fe_avalid_i <= 1'b1;
         fe_addr_i   <= addr;
         fe_wdata_i  <= data;
         fe_wstrb_i  <= strb;
         n = 0;
         @(negedge clk_i);
         while (!fe_ready_o && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
         end
         if (!fe_ready_o) begin
            timed_out = 1'b1;
            $display("front-end request was never accepted");
         end else begin
            @(posedge clk_i);
            fe_avalid_i <= 1'b0;
         end
      end
   endtask

   task automatic wait_line();
      int n;
      if (!timed_out) begin
         n = 0;
         @(negedge clk_i);
         while (!fe_line_valid_o && n < TIMEOUT) begin
            @(negedge clk_i);
            n++;
         end
         if (!fe_line_valid_o) begin
            timed_out = 1'b1;
            $display("refill line never came back");
         end
      end
   endtask

   // shadow memory and handshake bookkeeping
   always @(posedge clk_i) begin
      logic [31:0] wa;
      logic [31:0] word;
      wa = {fe_addr_i[31:2], 2'b00};
      if (!rst_i && fe_avalid_i && fe_ready_o && fe_wstrb_i != '0) begin
         word = shadow_word(wa);
         for (int b = 0; b < cache_be_pkg::NBYTES; b++) begin
            if (fe_wstrb_i[b]) word[8*b +: 8] = fe_wdata_i[8*b +: 8];
         end
         shadow[wa] = word;
         exp_wr_q[exp_wr] = {fe_addr_i, fe_wdata_i, fe_wstrb_i};
         exp_wr++;
         wr_cnt++;
      end else if (!rst_i && fe_avalid_i && fe_ready_o) begin
         // the line as it stands when the read is taken
         line_base = {fe_addr_i[31:4], 4'h0};
         rd_idx = 0;
         for (int k = 0; k < cache_be_pkg::LINE_WORDS; k++) begin
            exp_line[32*k +: 32] = shadow_word(line_base + 32'(4 * k));
         end
      end
      if (!rst_i && be_avalid_o && be_ready_i && be_wstrb_o != '0) begin
         exp_rd++;
         drn_cnt++;
      end else if (!rst_i && be_avalid_o && be_ready_i) begin
         rd_idx++;
      end
      if (fe_line_valid_o) line_cnt++;
   end

   a_reset_idle: assert property (@(posedge clk_i) $fell(rst_i) |->
      (!be_avalid_o && !fe_line_valid_o && fe_ready_o && wtb_empty_o && wtb_level_o == '0))
      else log_error("outputs not idle after reset");
   a_write_order: assert property (@(posedge clk_i) disable iff (rst_i)
      (be_avalid_o && be_ready_i && be_wstrb_o != '0) |->
      (wr_cnt != drn_cnt && {be_addr_o, be_wdata_o, be_wstrb_o} == exp_head))
      else log_error("back-end write differs from the next front-end write");
   // an entry leaves the level when it is popped, before its write is taken
   a_level: assert property (@(posedge clk_i) disable iff (rst_i)
      int'(wtb_level_o) == wtb_occ &&
      wtb_full_o == (wtb_occ == cache_be_pkg::WTB_DEPTH) &&
      wtb_empty_o == (wtb_occ == 0))
      else log_error("buffer level or flags differ from accepted minus drained writes");
   a_full_stall: assert property (@(posedge clk_i) disable iff (rst_i)
      (wtb_full_o && fe_wstrb_i != '0) |-> !fe_ready_o)
      else log_error("write ready while the buffer is full");
   a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      (be_avalid_o && !be_ready_i) |=> (be_avalid_o && $stable(be_addr_o) &&
                                        $stable(be_wdata_o) && $stable(be_wstrb_o)))
      else log_error("back-end request changed while stalled");
   a_refill_addr: assert property (@(posedge clk_i) disable iff (rst_i)
      (be_avalid_o && be_ready_i && be_wstrb_o == '0) |->
      (rd_idx < cache_be_pkg::LINE_WORDS && be_addr_o == line_base + 32'(4 * rd_idx)))
      else log_error("refill read at the wrong word address");
   a_line_data: assert property (@(posedge clk_i) disable iff (rst_i)
      fe_line_valid_o |-> fe_line_o == exp_line)
      else log_error("refill line differs from the shadow memory");
   a_read_after_drain: assert property (@(posedge clk_i) disable iff (rst_i)
      (be_avalid_o && be_wstrb_o == '0) |-> wtb_empty_o)
      else log_error("back-end read while the buffer holds writes");

   initial begin
      logic [31:0] base;
      int          n;
      void'($urandom(52));
      rst_i        = 1'b1;
      fe_avalid_i  = 1'b0;
      fe_addr_i    = '0;
      fe_wdata_i   = '0;
      fe_wstrb_i   = '0;
      mem_ready_en = 1'b1;
      repeat (5) @(posedge clk_i);
      rst_i <= 1'b0;

      // memory stalled, keep writing until the buffer is full
      mem_ready_en <= 1'b0;
      n = 0;
      @(negedge clk_i);
      while (!timed_out && !wtb_full_o && n < 2 * cache_be_pkg::WTB_DEPTH + 2) begin
         send_req(32'h0000_2000 + 32'(4 * n), $urandom, 4'hf);
         @(negedge clk_i);
         n++;
      end
      if (!timed_out && !wtb_full_o) begin
         timed_out = 1'b1;
         $display("buffer never filled while the memory was stalled");
      end
      if (!timed_out) begin
         repeat (4) @(posedge clk_i);
         mem_ready_en <= 1'b1;
      end

      // byte-masked writes into one line, then a miss on that line
      for (int l = 0; l < 4 && !timed_out; l++) begin
         base = 32'h0000_1000 + 32'($urandom % 64) * 32'd16;
         for (int i = 0; i < 6; i++) begin
            send_req(base + 32'($urandom % 4) * 32'd4, $urandom, 4'($urandom % 15 + 1));
         end
         send_req(base + 32'($urandom % 16), '0, '0);
         wait_line();
      end
      end_run();
   end

endmodule

`default_nettype wire
